//--- Makefile
SIM := obj_dir/Vtb_fpu_addsub

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): sim.f $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
	verilator --binary --timing --assert --top-module tb_fpu_addsub -Mdir obj_dir -f sim.f

# Pass only when the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

//--- hdl/fcsr_regs.sv
`timescale 1ns/10ps

module fcsr_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                cfg_we_i,
  input  fpu_pkg::csr_addr_e  cfg_addr_i,
  input  logic [7:0]          cfg_wdata_i,
  output logic [7:0]          cfg_rdata_o,
  input  logic                acc_valid_i,  // A result leaves this cycle
  input  fpu_pkg::fflags_t    acc_flags_i,
  output fpu_pkg::frm_e       frm_o
);

  fpu_pkg::frm_e    frm_q;
  fpu_pkg::frm_e    frm_d;
  fpu_pkg::fflags_t fflags_q;  // Accrued exception flags
  fpu_pkg::fflags_t fflags_d;

  // Write first, then accrue on top so no flag is lost
  always_comb begin
    frm_d    = frm_q;
    fflags_d = fflags_q;
    if (cfg_we_i) begin
      case (cfg_addr_i)
        fpu_pkg::CSR_FFLAGS: fflags_d = cfg_wdata_i[4:0];
        fpu_pkg::CSR_FRM:    frm_d    = fpu_pkg::frm_e'(cfg_wdata_i[2:0]);
        fpu_pkg::CSR_FCSR: begin
          frm_d    = fpu_pkg::frm_e'(cfg_wdata_i[7:5]);  // frm above fflags
          fflags_d = cfg_wdata_i[4:0];
        end
        default: ;  // Unmapped address ignored
      endcase
    end
    if (acc_valid_i) fflags_d = fflags_d | acc_flags_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      frm_q    <= fpu_pkg::FRM_RNE;
      fflags_q <= '0;
    end else begin
      frm_q    <= frm_d;
      fflags_q <= fflags_d;
    end
  end

  always_comb begin
    case (cfg_addr_i)
      fpu_pkg::CSR_FFLAGS: cfg_rdata_o = {3'b000, fflags_q};
      fpu_pkg::CSR_FRM:    cfg_rdata_o = {5'b00000, frm_q};
      fpu_pkg::CSR_FCSR:   cfg_rdata_o = {frm_q, fflags_q};
      default:             cfg_rdata_o = 8'h00;
    endcase
  end

  assign frm_o = frm_q;

endmodule

//--- hdl/fp_addsub.sv
`timescale 1ns/10ps

module fp_addsub (
  input  fpu_pkg::fp_aligned_t aligned_i,
  output fpu_pkg::fpu_res_t    res_o
);

  fpu_pkg::fp_unpacked_t a;
  fpu_pkg::fp_unpacked_t b;
  logic              a_ge;     // |a| >= |b| after alignment
  logic              eff_sub;  // Signs differ so magnitudes subtract
  logic              sign;     // Sign of the larger magnitude
  logic [27:0]       big;
  logic [27:0]       little;
  logic [27:0]       raw;      // Carry, hidden, 23 frac, G, R, S
  logic              zero;     // Exact cancellation
  logic [4:0]        lead;     // Leading one of raw
  logic [26:0]       norm;     // Hidden bit back at 26
  logic signed [9:0] exp_n;    // Exponent after normalisation
  logic signed [9:0] exp_r;    // Exponent after rounding
  logic              last;
  logic              guard;
  logic              sticky;   // Round bit folded in
  logic              inexact;
  logic              inc;      // Round up the magnitude
  logic              invalid;  // Reserved mode reached the datapath
  logic [24:0]       rounded;
  logic              carry;    // Rounding overflowed the mantissa
  logic [22:0]       frac;

  assign a = aligned_i.a;
  assign b = aligned_i.b;

  // Always big minus little so the magnitude never goes negative
  assign a_ge    = a.mant >= b.mant;
  assign eff_sub = a.sign != b.sign;
  assign big     = {1'b0, a_ge ? a.mant : b.mant};
  assign little  = {1'b0, a_ge ? b.mant : a.mant};
  assign raw     = eff_sub ? big - little : big + little;
  assign sign    = a_ge ? a.sign : b.sign;  // Tie keeps the sign of a
  assign zero    = raw == 28'd0;

  fp_lead_one fp_lead_one_i (
    .mant_i (raw),
    .pos_o  (lead)
  );

  // Carry out shifts right by one and anything else shifts left
  assign norm  = (lead == 5'd27) ? {raw[27:2], |raw[1:0]}
                                 : raw[26:0] << (5'd26 - lead);
  assign exp_n = $signed({2'b00, a.exp}) + $signed({5'b00000, lead}) - 10'sd26;

  assign last    = norm[3];    // LSB of the kept fraction
  assign guard   = norm[2];
  assign sticky  = |norm[1:0];
  assign inexact = guard | sticky;

  always_comb begin
    inc     = 1'b0;
    invalid = 1'b0;
    case (aligned_i.rm)
      fpu_pkg::FRM_RNE: inc = guard & (last | sticky);
      fpu_pkg::FRM_RTZ: inc = 1'b0;                // Truncate
      fpu_pkg::FRM_RDN: inc = sign & inexact;      // Bigger magnitude when negative
      fpu_pkg::FRM_RUP: inc = ~sign & inexact;
      fpu_pkg::FRM_RMM: inc = guard;               // Ties away from zero
      default:          invalid = 1'b1;            // 5, 6 and an unresolved 7
    endcase
  end

  assign rounded = {1'b0, norm[26:3]} + 25'(inc);
  assign carry   = rounded[24];
  assign frac    = carry ? rounded[23:1] : rounded[22:0];  // 1.111..+1 gives 10.000..
  assign exp_r   = exp_n + $signed({9'd0, carry});

  // Invalid mode takes precedence in the result select
  always_comb begin
    res_o.flags = '0;
    if (invalid) begin
      res_o.value    = 32'h7FC00000;  // Canonical quiet NaN
      res_o.flags.nv = 1'b1;
    end else if (zero) begin
      res_o.value = {sign, 8'h00, 23'd0};  // Exact zero raises no flags
    end else if (exp_r >= 10'sd255) begin
      res_o.value    = {sign, 8'hFF, 23'd0};  // Signed infinity
      res_o.flags.of = 1'b1;
      res_o.flags.nx = 1'b1;
    end else if (exp_r < 10'sd1) begin
      res_o.value    = {sign, 8'h00, 23'd0};  // Flush to signed zero
      res_o.flags.uf = 1'b1;
      res_o.flags.nx = 1'b1;
    end else begin
      res_o.value    = {sign, exp_r[7:0], frac};
      res_o.flags.nx = inexact;
    end
  end

endmodule

//--- hdl/fp_align.sv
`timescale 1ns/10ps

module fp_align (
  input  fpu_pkg::fp32_t       a_i,
  input  fpu_pkg::fp32_t       b_i,
  input  fpu_pkg::fpu_op_e     op_i,
  input  fpu_pkg::frm_e        rm_i,
  output fpu_pkg::fp_aligned_t aligned_o
);

  fpu_pkg::fp_unpacked_t ua;         // Operand a before shift
  fpu_pkg::fp_unpacked_t ub;         // Operand b before shift
  logic                  a_big;      // a has the larger or equal exponent
  logic [7:0]            diff;       // Exponent difference
  logic [26:0]           sm_mant;    // Mantissa of the smaller operand
  logic [26:0]           sm_shift;
  logic [26:0]           lost_mask;  // Bits pushed out by the shift
  logic                  sticky;

  always_comb begin
    ua.sign = a_i.sign;
    ua.exp  = a_i.exp;
    ua.mant = {|a_i.exp, a_i.frac, 3'b000};  // Hidden bit only when exp nonzero
    ub.sign = b_i.sign ^ (op_i == fpu_pkg::OP_SUB);  // a - b is a + (-b)
    ub.exp  = b_i.exp;
    ub.mant = {|b_i.exp, b_i.frac, 3'b000};
  end

  assign a_big     = ua.exp >= ub.exp;
  assign diff      = a_big ? ua.exp - ub.exp : ub.exp - ua.exp;
  assign sm_mant   = a_big ? ub.mant : ua.mant;
  assign sm_shift  = sm_mant >> diff;
  assign lost_mask = ~({27{1'b1}} << diff);  // All ones once diff passes 26
  assign sticky    = |(sm_mant & lost_mask);

  // Both operands leave with the larger exponent
  always_comb begin
    aligned_o    = '{a: ua, b: ub, rm: rm_i};
    if (a_big) begin
      aligned_o.b.exp  = ua.exp;
      aligned_o.b.mant = {sm_shift[26:1], sm_shift[0] | sticky};
    end else begin
      aligned_o.a.exp  = ub.exp;
      aligned_o.a.mant = {sm_shift[26:1], sm_shift[0] | sticky};
    end
  end

endmodule

//--- hdl/fp_lead_one.sv
`timescale 1ns/10ps

// Priority encoder over the raw sum
// Bit 27 is the carry out, bit 26 the hidden bit position
module fp_lead_one (
  input  logic [27:0] mant_i,
  output logic [4:0]  pos_o
);

  // Later (higher) hits overwrite earlier ones
  always_comb begin
    pos_o = 5'd0;  // Zero input also lands here
    for (int i = 0; i < 28; i++) begin
      if (mant_i[i]) begin
        pos_o = 5'(i);
      end
    end
  end

endmodule

//--- hdl/fpu_addsub_top.sv
`timescale 1ns/10ps
`include "fpu_params.svh"

module fpu_addsub_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  input  fpu_pkg::fpu_req_t  req_i,
  output logic               req_credit_o,  // One entry freed
  output logic               res_valid_o,
  output fpu_pkg::fpu_res_t  res_o,
  input  logic               res_credit_i,  // Receiver freed a slot
  input  logic               cfg_we_i,
  input  fpu_pkg::csr_addr_e cfg_addr_i,
  input  logic [7:0]         cfg_wdata_i,
  output logic [7:0]         cfg_rdata_o
);

  localparam int CNT_W = `FPU_CNT_W;

  fpu_pkg::fpu_req_t    head;       // Oldest buffered request
  logic                 empty;
  logic                 issue;
  logic [CNT_W-1:0]     res_cred_q;  // Result slots still free
  fpu_pkg::frm_e        frm;
  fpu_pkg::frm_e        rm_res;      // DYN resolved
  fpu_pkg::fp_aligned_t aligned;
  fpu_pkg::fp_aligned_t s1_data_q;
  logic                 s1_valid_q;
  fpu_pkg::fpu_res_t    result;
  fpu_pkg::fpu_res_t    s2_data_q;
  logic                 s2_valid_q;

  fpu_req_fifo #(.DEPTH(`FPU_REQ_DEPTH)) fpu_req_fifo_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (req_valid_i),  // Sender only sends with a credit
    .push_data_i (req_i),
    .pop_i       (issue),
    .pop_data_o  (head),
    .empty_o     (empty)
  );

  // Issue reserves an output slot up front
  assign issue        = !empty && (res_cred_q != '0);
  assign req_credit_o = issue;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) res_cred_q <= CNT_W'(`FPU_RES_CREDITS);
    else          res_cred_q <= res_cred_q + CNT_W'(res_credit_i) - CNT_W'(issue);
  end

  always_comb begin
    if (head.rm == fpu_pkg::FRM_DYN) rm_res = frm;
    else                             rm_res = head.rm;
  end

  fp_align fp_align_i (
    .a_i       (head.a),
    .b_i       (head.b),
    .op_i      (head.op),
    .rm_i      (rm_res),
    .aligned_o (aligned)
  );

  fp_addsub fp_addsub_i (
    .aligned_i (s1_data_q),
    .res_o     (result)
  );

  // Stage valids, reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= issue;
      s2_valid_q <= s1_valid_q;  // Valid for exactly one cycle
    end
  end

  // Stage payloads, load only with a valid item
  always_ff @(posedge clk_i) begin
    if (issue)      s1_data_q <= aligned;
    if (s1_valid_q) s2_data_q <= result;
  end

  fcsr_regs fcsr_regs_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .acc_valid_i (s2_valid_q),       // Flags accrue as the result leaves
    .acc_flags_i (s2_data_q.flags),
    .frm_o       (frm)
  );

  assign res_valid_o = s2_valid_q;
  assign res_o       = s2_data_q;

endmodule

//--- hdl/fpu_params.svh
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// Request buffer entries
// Also the number of input credits the sender holds after reset
`define FPU_REQ_DEPTH 4

// Result slots the receiver grants after reset
`define FPU_RES_CREDITS 2

// Credit and occupancy counters
// Must hold the value FPU_REQ_DEPTH
`define FPU_CNT_W 3

`endif

//--- hdl/fpu_pkg.sv
package fpu_pkg;

  // IEEE 754 binary32 layout
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp32_t;

  // RISC-V rounding modes, 5 and 6 are reserved
  typedef enum logic [2:0] {
    FRM_RNE = 3'd0,  // Nearest, ties to even
    FRM_RTZ = 3'd1,  // Towards zero
    FRM_RDN = 3'd2,  // Towards -inf
    FRM_RUP = 3'd3,  // Towards +inf
    FRM_RMM = 3'd4,  // Nearest, ties to max magnitude
    FRM_DYN = 3'd7   // Take mode from frm
  } frm_e;

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } fpu_op_e;

  // Same order as the fflags CSR
  typedef struct packed {
    logic nv;  // Invalid
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } fflags_t;

  typedef struct packed {
    fpu_op_e op;
    frm_e    rm;
    fp32_t   a;
    fp32_t   b;
  } fpu_req_t;

  typedef struct packed {
    fp32_t   value;
    fflags_t flags;
  } fpu_res_t;

  // Mantissa is hidden bit, 23 fraction bits, then guard, round, sticky
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [26:0] mant;
  } fp_unpacked_t;

  typedef struct packed {
    fp_unpacked_t a;
    fp_unpacked_t b;   // Sign already flipped for subtract
    frm_e         rm;  // Never DYN here
  } fp_aligned_t;

  typedef enum logic [1:0] {
    CSR_FFLAGS = 2'd1,
    CSR_FRM    = 2'd2,
    CSR_FCSR   = 2'd3
  } csr_addr_e;

endpackage

//--- hdl/fpu_req_fifo.sv
`timescale 1ns/10ps
`include "fpu_params.svh"

module fpu_req_fifo #(
  parameter int DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              push_i,
  input  fpu_pkg::fpu_req_t push_data_i,
  input  logic              pop_i,
  output fpu_pkg::fpu_req_t pop_data_o,
  output logic              empty_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  fpu_pkg::fpu_req_t      mem [DEPTH];  // Payload only, no reset
  logic [AW-1:0]          wr_ptr;
  logic [AW-1:0]          rd_ptr;
  logic [`FPU_CNT_W-1:0]  count;        // Occupancy

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr] <= push_data_i;  // Credits keep this from overflowing
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_i)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither, no change
      endcase
    end
  end

  assign pop_data_o = mem[rd_ptr];  // Head straight from storage
  assign empty_o    = count == '0;

endmodule

//--- sim.f
+incdir+hdl
hdl/fpu_pkg.sv
hdl/fp_align.sv
hdl/fp_lead_one.sv
hdl/fp_addsub.sv
hdl/fcsr_regs.sv
hdl/fpu_req_fifo.sv
hdl/fpu_addsub_top.sv
tb/tb_fpu_addsub.sv

//--- tb/tb_fpu_addsub.sv
`timescale 1ns/10ps
`include "fpu_params.svh"

module tb_fpu_addsub;

  localparam int MAX_REQ = 256;  // Expected-result slots, index is 8 bits

  logic               clk = 1'b0;
  logic               rst_n_i;
  logic               req_valid_i;
  fpu_pkg::fpu_req_t  req_i;
  logic               req_credit_o;
  logic               res_valid_o;
  fpu_pkg::fpu_res_t  res_o;
  logic               res_credit_i;
  logic               cfg_we_i;
  fpu_pkg::csr_addr_e cfg_addr_i;
  logic [7:0]         cfg_wdata_i;
  logic [7:0]         cfg_rdata_o;

  logic [31:0] exp_value [MAX_REQ];  // Expected results in request order
  logic [4:0]  exp_flags [MAX_REQ];
  int          sent_cnt = 0;          // Requests driven
  int          credit_pulses = 0;     // req_credit_o pulses seen
  int          results_received = 0;
  int          credits_returned = 0;  // res_credit_i pulses driven
  logic        hold_credits;          // Withhold result credits
  logic [4:0]  fflags_model;          // Accrued flags as the DUT should hold them
  logic [2:0]  frm_model;
  int          base;

  fpu_addsub_top fpu_addsub_top_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .res_credit_i (res_credit_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o)
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Exact binary32 of a small integer, magnitude below 2^24
  function automatic logic [31:0] int_to_fp32(input logic sign, input int unsigned mag);
    int          msb;
    logic [31:0] m;
    if (mag == 0) return {sign, 31'd0};
    msb = 0;
    for (int i = 0; i < 24; i++) begin
      if (((mag >> i) & 32'd1) != 0) msb = i;
    end
    m = mag << (23 - msb);  // Leading one lands on the hidden bit
    return {sign, 8'(127 + msb), m[22:0]};
  endfunction

  // Spends one input credit, waits while none is left
  task automatic send_req(input fpu_pkg::fpu_op_e op, input fpu_pkg::frm_e rm,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] ev, input logic [4:0] ef);
    while (`FPU_REQ_DEPTH - sent_cnt + credit_pulses == 0) begin
      @(posedge clk);
      #1;
    end
    exp_value[8'(sent_cnt)] = ev;
    exp_flags[8'(sent_cnt)] = ef;
    fflags_model = fflags_model | ef;  // Flags accrue as results leave
    req_valid_i  = 1'b1;
    req_i.op     = op;
    req_i.rm     = rm;
    req_i.a      = a;
    req_i.b      = b;
    sent_cnt++;
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  // All results in and every result credit handed back
  task automatic wait_idle();
    while (results_received != sent_cnt || credits_returned != results_received) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);  // Last flags accrue, last credit is counted
    #1;
  endtask

  task automatic csr_write(input fpu_pkg::csr_addr_e addr, input logic [7:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    case (addr)
      fpu_pkg::CSR_FFLAGS: fflags_model = data[4:0];
      fpu_pkg::CSR_FRM:    frm_model    = data[2:0];
      default: begin
        frm_model    = data[7:5];
        fflags_model = data[4:0];
      end
    endcase
    @(posedge clk);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task automatic csr_check(input fpu_pkg::csr_addr_e addr, input logic [7:0] expected);
    cfg_addr_i = addr;
    @(negedge clk);  // Read path is combinational
    assert (cfg_rdata_o == expected)
      else stop_with_failure($sformatf("ERROR cfg_rdata_o expected %h got %h",
                                       expected, cfg_rdata_o));
    @(posedge clk);
    #1;
  endtask

  // Integer operands, every sum and difference is exact in binary32
  task automatic run_exact(input fpu_pkg::frm_e rm);
    logic             sa;
    logic             sb;
    int unsigned      ma;
    int unsigned      mb;
    int               vr;
    logic [31:0]      fa;
    logic [31:0]      fb;
    logic [31:0]      fr;
    fpu_pkg::fpu_op_e op;
    for (int n = 0; n < 8; n++) begin
      sa = $urandom_range(1, 0) != 0;
      sb = $urandom_range(1, 0) != 0;
      ma = $urandom_range(32'hFFFFF, 0);  // Below 2^20
      mb = $urandom_range(32'hFFFFF, 0);
      op = ($urandom_range(1, 0) != 0) ? fpu_pkg::OP_SUB : fpu_pkg::OP_ADD;
      fa = int_to_fp32(sa, ma);
      fb = int_to_fp32(sb, mb);
      vr = sa ? -int'(ma) : int'(ma);
      if (op == fpu_pkg::OP_ADD) vr = sb ? vr - int'(mb) : vr + int'(mb);
      else                       vr = sb ? vr + int'(mb) : vr - int'(mb);
      if (vr == 0) fr = {sa, 31'd0};  // Cancellation keeps the sign of a
      else         fr = int_to_fp32(vr < 0, (vr < 0) ? -vr : vr);
      send_req(op, rm, fa, fb, fr, 5'b00000);
    end
    send_req(fpu_pkg::OP_SUB, rm, fa, fa, {fa[31], 31'd0}, 5'b00000);  // a - a
  endtask

  // 1.0 and 2^-24 sit exactly half an ulp apart
  task automatic run_rounding(input fpu_pkg::frm_e req_rm, input fpu_pkg::frm_e eff_rm);
    logic up_pos;
    logic up_neg;
    up_pos = (eff_rm == fpu_pkg::FRM_RUP) || (eff_rm == fpu_pkg::FRM_RMM);
    up_neg = (eff_rm == fpu_pkg::FRM_RDN) || (eff_rm == fpu_pkg::FRM_RMM);
    send_req(fpu_pkg::OP_ADD, req_rm, 32'h3F800000, 32'h33800000,
             up_pos ? 32'h3F800001 : 32'h3F800000, 5'b00001);
    send_req(fpu_pkg::OP_SUB, req_rm, 32'hBF800000, 32'h33800000,  // -1.0 - 2^-24
             up_neg ? 32'hBF800001 : 32'hBF800000, 5'b00001);
  endtask

  // Result credits go back one at a time with a random gap
  initial begin : credit_return
    int gap;
    gap          = 0;
    res_credit_i = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      res_credit_i = 1'b0;
      if (rst_n_i && !hold_credits) begin
        if (gap > 0) begin
          gap--;
        end else if (credits_returned < results_received) begin
          res_credit_i = 1'b1;
          credits_returned++;
          gap = $urandom_range(5, 0);
        end
      end
    end
  end

  // Checks sampled mid-cycle, away from both edges
  always @(negedge clk) begin
    if (rst_n_i) begin
      assert (sent_cnt != 0 || (!res_valid_o && !req_credit_o))
        else stop_with_failure("Output activity before the first request was sent");
      if (req_credit_o) credit_pulses++;
      assert (credit_pulses <= sent_cnt)
        else stop_with_failure("Input credit returned with no request to match it");
      if (res_valid_o) begin
        assert (results_received < sent_cnt)
          else stop_with_failure("Result arrived with no request outstanding");
        assert (results_received < `FPU_RES_CREDITS + credits_returned)
          else stop_with_failure("More results arrived than result credits were granted");
        assert (res_o.value == exp_value[8'(results_received)])
          else stop_with_failure($sformatf("ERROR res_o.value expected %h got %h",
                                           exp_value[8'(results_received)], res_o.value));
        assert (res_o.flags == exp_flags[8'(results_received)])
          else stop_with_failure($sformatf("ERROR res_o.flags expected %h got %h",
                                           exp_flags[8'(results_received)], res_o.flags));
        results_received++;
      end
    end
  end

  // Budget grows with every request sent
  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 200 * sent_cnt + 1000)
        stop_with_failure("Watchdog expired, the DUT stopped making progress");
    end
  end

  initial begin : stimulus
    void'($urandom(32'h6e565bff));
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = fpu_pkg::CSR_FFLAGS;
    cfg_wdata_i  = 8'h00;
    hold_credits = 1'b0;
    fflags_model = 5'b00000;
    frm_model    = 3'd0;  // RNE after reset
    repeat (10) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    repeat (5) @(posedge clk);  // Outputs must stay quiet here
    #1;

    for (int m = 0; m < 5; m++) run_exact(fpu_pkg::frm_e'(3'(m)));
    for (int m = 0; m < 5; m++) run_rounding(fpu_pkg::frm_e'(3'(m)), fpu_pkg::frm_e'(3'(m)));

    // Reserved modes, static and through frm
    send_req(fpu_pkg::OP_ADD, fpu_pkg::frm_e'(3'd5), 32'h3F800000, 32'h40000000,
             32'h7FC00000, 5'b10000);
    send_req(fpu_pkg::OP_SUB, fpu_pkg::frm_e'(3'd6), 32'h3F800000, 32'h40000000,
             32'h7FC00000, 5'b10000);
    wait_idle();
    csr_write(fpu_pkg::CSR_FRM, 8'h05);
    send_req(fpu_pkg::OP_ADD, fpu_pkg::FRM_DYN, 32'h3F800000, 32'h40000000,
             32'h7FC00000, 5'b10000);
    wait_idle();
    csr_write(fpu_pkg::CSR_FRM, 8'h00);

    // Largest finite plus itself
    send_req(fpu_pkg::OP_ADD, fpu_pkg::FRM_RNE, 32'h7F7FFFFF, 32'h7F7FFFFF,
             32'h7F800000, 5'b00101);

    // Burst at full input credit, result credits held back
    wait_idle();
    hold_credits = 1'b1;
    base         = results_received;
    for (int n = 0; n < `FPU_REQ_DEPTH; n++) begin
      send_req(fpu_pkg::OP_ADD, fpu_pkg::FRM_RNE, int_to_fp32(1'b0, n + 1),
               32'h3F800000, int_to_fp32(1'b0, n + 2), 5'b00000);  // n+1 plus 1.0
    end
    repeat (20) @(posedge clk);
    #1;
    assert (results_received - base == `FPU_RES_CREDITS)
      else stop_with_failure($sformatf("ERROR results_received expected %h got %h",
                                       `FPU_RES_CREDITS, results_received - base));
    hold_credits = 1'b0;
    wait_idle();

    // Register block, flags accrued since reset first
    csr_check(fpu_pkg::CSR_FFLAGS, {3'b000, fflags_model});
    csr_check(fpu_pkg::CSR_FCSR, {frm_model, fflags_model});
    csr_write(fpu_pkg::CSR_FFLAGS, 8'h00);
    csr_check(fpu_pkg::CSR_FFLAGS, 8'h00);
    csr_write(fpu_pkg::CSR_FRM, 8'h03);  // RUP
    csr_check(fpu_pkg::CSR_FRM, 8'h03);
    run_rounding(fpu_pkg::FRM_DYN, fpu_pkg::FRM_RUP);
    wait_idle();
    csr_check(fpu_pkg::CSR_FFLAGS, {3'b000, fflags_model});
    csr_check(fpu_pkg::CSR_FCSR, {frm_model, fflags_model});
    csr_write(fpu_pkg::CSR_FCSR, 8'h00);
    csr_check(fpu_pkg::CSR_FCSR, 8'h00);

    wait_idle();
    if (credit_pulses == sent_cnt) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      stop_with_failure($sformatf("ERROR req_credit_o count expected %h got %h",
                                  sent_cnt, credit_pulses));
    end
  end

endmodule
